/* hdl/rv_pkg.sv */
package rv_pkg;

    localparam int          XLEN       = 32;
    localparam int          BUF_HWORDS = 4;
    localparam int          BUF_CNT_W  = 3;
    localparam logic [31:0] RESET_PC   = 32'h0000_0000;

    // Major opcodes seen by the expander and the predecoder
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // RVC_NONE marks a 32-bit instruction passing through
    typedef enum logic [3:0] {
        RVC_NONE,
        RVC_ADDI,
        RVC_LI,
        RVC_MV,
        RVC_ADD,
        RVC_J,
        RVC_BEQZ,
        RVC_BNEZ,
        RVC_ILLEGAL
    } rvc_op_e;

    typedef enum logic [2:0] {
        CLS_OTHER,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_ILLEGAL
    } instr_class_e;

    typedef struct packed {
        logic            valid;
        logic            is_comp;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } buf_out_t;

    typedef struct packed {
        instr_class_e    cls;
        logic [XLEN-1:0] next_pc;
        logic [XLEN-1:0] target;
        logic            is_comp;
    } predec_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
        instr_class_e    cls;
        logic [XLEN-1:0] next_pc;
        logic [XLEN-1:0] target;
        logic            is_comp;
    } fetch_pkt_t;

    // CJ format offset, sign extended
    function automatic logic [XLEN-1:0] c_j_imm(input logic [15:0] c);
        return {{20{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    endfunction

    // CB format offset, sign extended
    function automatic logic [XLEN-1:0] c_b_imm(input logic [15:0] c);
        return {{23{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3], 1'b0};
    endfunction

endpackage

/* hdl/rv_fetch_ctrl.sv */
`timescale 1ns/1ps

module rv_fetch_ctrl
    import rv_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_reset_n,
    input  logic            i_pc_select,
    input  logic [31:0]     i_redirect_pc,
    input  logic            i_mem_ack,
    input  logic            i_free_dword_or_more,
    input  logic [31:0]     i_pc_incr,
    output logic            o_mem_req,
    output logic [31:0]     o_mem_addr,
    output logic            o_fetch_pc1,
    output logic            o_ack_valid
);

    logic [XLEN-1:0] fetch_pc;
    logic            outstanding;
    logic            discard;
    logic            mem_req;

    // One request in flight at most, and only with room for a full word
    assign mem_req = !outstanding & i_free_dword_or_more & !i_pc_select;

    // Ack of a request issued before a redirect is dropped
    assign o_ack_valid = i_mem_ack & !discard;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            fetch_pc    <= RESET_PC;
            outstanding <= 1'b0;
            discard     <= 1'b0;
        end
        else
        begin
            if (mem_req)
                outstanding <= 1'b1;
            else if (i_mem_ack)
                outstanding <= 1'b0;

            if (i_pc_select)
            begin
                fetch_pc <= i_redirect_pc;
                // An ack in the same cycle closes the old request already
                discard  <= outstanding & !i_mem_ack;
            end
            else
            begin
                if (o_ack_valid)
                    fetch_pc <= fetch_pc + i_pc_incr;
                if (i_mem_ack)
                    discard <= 1'b0;
            end
        end
    end

    assign o_mem_req   = mem_req;
    assign o_mem_addr  = {fetch_pc[XLEN-1:2], 2'b00};
    assign o_fetch_pc1 = fetch_pc[1];

endmodule

/* hdl/rv_fetch_buf.sv */
`timescale 1ns/1ps

module rv_fetch_buf
    import rv_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_reset_n,
    input  logic            i_pc_select,
    input  logic            i_ack,
    input  logic            i_decode_ready,
    input  logic [31:0]     i_data,
    input  logic            i_fetch_pc1,
    input  logic [31:0]     i_fetch_pc_next,
    output logic            o_free_dword_or_more,
    output logic [31:0]     o_pc_incr,
    output buf_out_t        o_buf_out
);

    // Slot 0 sits in the low halfword and is the head of the stream
    logic [16*BUF_HWORDS-1:0] buf_q;
    logic [16*BUF_HWORDS-1:0] buf_next;
    logic [BUF_CNT_W-1:0]     free_cnt;
    logic [BUF_CNT_W-1:0]     free_cnt_next;
    logic [BUF_CNT_W-1:0]     cnt;
    logic [BUF_CNT_W-1:0]     cnt_pop;
    logic [BUF_CNT_W-1:0]     cnt_next;
    logic [BUF_CNT_W-1:0]     pop_n;
    logic [BUF_CNT_W-1:0]     push_n;
    logic [XLEN-1:0]          pc;
    logic [XLEN-1:0]          pc_next;
    logic                     fetch_pc1_q;
    logic                     move;
    logic                     empty;
    logic                     out_comp;
    logic                     next_comp;
    logic                     have_valid_next;
    logic                     push_word;
    logic                     push_double_word;
    logic                     pop_word;
    logic                     pop_double_word;

    assign cnt      = BUF_CNT_W'(BUF_HWORDS) - free_cnt;
    assign empty    = (free_cnt == BUF_CNT_W'(BUF_HWORDS));
    assign out_comp = (buf_q[1:0] != 2'b11);

    // Fetch from an odd halfword only brings the upper half of the word
    assign push_double_word = i_ack & !fetch_pc1_q & (free_cnt > 1);
    assign push_word        = i_ack & fetch_pc1_q & (free_cnt != 0);
    assign pop_double_word  = move & !out_comp & !empty;
    assign pop_word         = move & out_comp & !empty;

    assign pop_n  = pop_double_word ? 3'd2 : (pop_word ? 3'd1 : 3'd0);
    assign push_n = push_double_word ? 3'd2 : (push_word ? 3'd1 : 3'd0);

    always_comb
    begin
        cnt_pop  = cnt - pop_n;
        buf_next = buf_q >> (16 * pop_n);
        if (push_word)
            buf_next[16*cnt_pop +: 16] = i_data[31:16];
        if (push_double_word)
        begin
            buf_next[16*cnt_pop +: 16]       = i_data[15:0];
            buf_next[16*(cnt_pop + 1) +: 16] = i_data[31:16];
        end
        if (i_pc_select)
            buf_next = '0;
    end

    assign free_cnt_next = i_pc_select ? BUF_CNT_W'(BUF_HWORDS) :
                           free_cnt + pop_n - push_n;

    assign pc_next = i_pc_select ? i_fetch_pc_next : pc + XLEN'({pop_n, 1'b0});

    // Look ahead at the state after this edge so move never sees a partial instruction
    assign cnt_next        = BUF_CNT_W'(BUF_HWORDS) - free_cnt_next;
    assign next_comp       = (buf_next[1:0] != 2'b11);
    assign have_valid_next = (cnt_next != 0) & (next_comp | (cnt_next > 1));

    always_ff @(posedge i_clk)
    begin
        buf_q <= buf_next;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            free_cnt    <= BUF_CNT_W'(BUF_HWORDS);
            move        <= 1'b0;
            pc          <= RESET_PC;
            fetch_pc1_q <= 1'b0;
        end
        else
        begin
            free_cnt    <= free_cnt_next;
            move        <= i_decode_ready & have_valid_next;
            pc          <= pc_next;
            fetch_pc1_q <= i_fetch_pc1;
        end
    end

    assign o_free_dword_or_more = (free_cnt_next > 1);
    assign o_pc_incr            = fetch_pc1_q ? 32'd2 : 32'd4;

    assign o_buf_out.valid   = move;
    assign o_buf_out.is_comp = out_comp;
    assign o_buf_out.pc      = pc;
    assign o_buf_out.instr   = move ? {(out_comp ? 16'h0000 : buf_q[31:16]), buf_q[15:0]} :
                                      '0;

endmodule

/* hdl/rv_rvc_expand.sv */
`timescale 1ns/1ps

module rv_rvc_expand
    import rv_pkg::*;
(
    input  buf_out_t        i_buf,
    output logic [31:0]     o_instr,
    output rvc_op_e         o_op
);

    logic [15:0]     c;
    logic [4:0]      rd;
    logic [4:0]      rs2;
    logic [4:0]      rs1p;
    logic [XLEN-1:0] imm6;
    logic [XLEN-1:0] jimm;
    logic [XLEN-1:0] bimm;
    rvc_op_e         op;
    logic [31:0]     exp_instr;

    assign c    = i_buf.instr[15:0];
    assign rd   = c[11:7];
    assign rs2  = c[6:2];
    // Three-bit register fields map onto x8..x15
    assign rs1p = {2'b01, c[9:7]};
    assign imm6 = {{26{c[12]}}, c[12], c[6:2]};
    assign jimm = c_j_imm(c);
    assign bimm = c_b_imm(c);

    always_comb
    begin
        op = RVC_ILLEGAL;
        case ({c[15:13], c[1:0]})
            5'b000_01: op = RVC_ADDI;
            5'b010_01: op = RVC_LI;
            5'b101_01: op = RVC_J;
            5'b110_01: op = RVC_BEQZ;
            5'b111_01: op = RVC_BNEZ;
            5'b100_10:
            begin
                // rs2 of zero is C.JR or C.JALR, outside the subset
                if ((rd != 5'd0) && (rs2 != 5'd0))
                    op = c[12] ? RVC_ADD : RVC_MV;
            end
            default: op = RVC_ILLEGAL;
        endcase
        if (!i_buf.is_comp)
            op = RVC_NONE;
    end

    always_comb
    begin
        case (op)
            RVC_NONE:
                exp_instr = i_buf.instr;
            RVC_ADDI:
                exp_instr = {imm6[11:0], rd, 3'b000, rd, OPC_OP_IMM};
            RVC_LI:
                exp_instr = {imm6[11:0], 5'd0, 3'b000, rd, OPC_OP_IMM};
            RVC_MV:
                exp_instr = {7'd0, rs2, 5'd0, 3'b000, rd, OPC_OP};
            RVC_ADD:
                exp_instr = {7'd0, rs2, rd, 3'b000, rd, OPC_OP};
            RVC_J:
                exp_instr = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], 5'd0, OPC_JAL};
            RVC_BEQZ:
                exp_instr = {bimm[12], bimm[10:5], 5'd0, rs1p, 3'b000,
                             bimm[4:1], bimm[11], OPC_BRANCH};
            RVC_BNEZ:
                exp_instr = {bimm[12], bimm[10:5], 5'd0, rs1p, 3'b001,
                             bimm[4:1], bimm[11], OPC_BRANCH};
            default:
                exp_instr = '0;
        endcase
    end

    assign o_instr = exp_instr;
    assign o_op    = op;

endmodule

/* hdl/rv_predecode.sv */
`timescale 1ns/1ps

module rv_predecode
    import rv_pkg::*;
(
    input  buf_out_t        i_buf,
    output predec_t         o_predec
);

    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] j_imm;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] target;
    instr_class_e    cls;

    assign instr = i_buf.instr;
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        cls = CLS_OTHER;
        imm = '0;
        if (!i_buf.is_comp)
        begin
            case (instr[6:0])
                OPC_BRANCH:
                begin
                    cls = CLS_BRANCH;
                    imm = b_imm;
                end
                OPC_JAL:
                begin
                    cls = CLS_JAL;
                    imm = j_imm;
                end
                OPC_JALR: cls = CLS_JALR;
                default:  cls = CLS_OTHER;
            endcase
        end
        else
        begin
            case ({instr[15:13], instr[1:0]})
                // C.JAL and C.J
                5'b001_01, 5'b101_01:
                begin
                    cls = CLS_JAL;
                    imm = c_j_imm(instr[15:0]);
                end
                5'b110_01, 5'b111_01:
                begin
                    cls = CLS_BRANCH;
                    imm = c_b_imm(instr[15:0]);
                end
                5'b100_10:
                begin
                    if ((instr[6:2] == 5'd0) && (instr[11:7] != 5'd0))
                        cls = CLS_JALR;
                end
                default: cls = CLS_OTHER;
            endcase
        end
    end

    assign next_pc = i_buf.pc + (i_buf.is_comp ? 32'd2 : 32'd4);
    // Register-indirect jumps have no static target
    assign target  = ((cls == CLS_BRANCH) || (cls == CLS_JAL)) ? i_buf.pc + imm : next_pc;

    assign o_predec = '{cls: cls, next_pc: next_pc, target: target, is_comp: i_buf.is_comp};

endmodule

/* hdl/rv_fetch_pkt.sv */
`timescale 1ns/1ps

module rv_fetch_pkt
    import rv_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_reset_n,
    input  logic            i_pc_select,
    input  buf_out_t        i_buf,
    input  logic [31:0]     i_instr,
    input  rvc_op_e         i_op,
    input  predec_t         i_predec,
    output fetch_pkt_t      o_pkt
);

    fetch_pkt_t pkt_q;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            pkt_q.valid <= 1'b0;
        end
        else
        begin
            // A redirect kills the packet leaving the buffer this cycle
            pkt_q.valid <= i_buf.valid & !i_pc_select;
            if (i_buf.valid)
            begin
                pkt_q.pc      <= i_buf.pc;
                pkt_q.instr   <= i_instr;
                pkt_q.cls     <= (i_op == RVC_ILLEGAL) ? CLS_ILLEGAL : i_predec.cls;
                pkt_q.next_pc <= i_predec.next_pc;
                pkt_q.target  <= i_predec.target;
                pkt_q.is_comp <= i_predec.is_comp;
            end
        end
    end

    assign o_pkt = pkt_q;

endmodule

/* hdl/rv_fetch_unit.sv */
`timescale 1ns/1ps

module rv_fetch_unit
    import rv_pkg::*;
(
    input  logic            i_clk,
    input  logic            i_reset_n,
    output logic            o_mem_req,
    output logic [31:0]     o_mem_addr,
    input  logic            i_mem_ack,
    input  logic [31:0]     i_mem_data,
    input  logic            i_pc_select,
    input  logic [31:0]     i_redirect_pc,
    input  logic            i_decode_ready,
    output fetch_pkt_t      o_pkt
);

    logic        free_dword_or_more;
    logic [31:0] pc_incr;
    logic        fetch_pc1;
    logic        ack_valid;
    buf_out_t    buf_out;
    logic [31:0] exp_instr;
    rvc_op_e     exp_op;
    predec_t     predec;

    rv_fetch_ctrl rv_fetch_ctrl_i (
        .i_clk                (i_clk),
        .i_reset_n            (i_reset_n),
        .i_pc_select          (i_pc_select),
        .i_redirect_pc        (i_redirect_pc),
        .i_mem_ack            (i_mem_ack),
        .i_free_dword_or_more (free_dword_or_more),
        .i_pc_incr            (pc_incr),
        .o_mem_req            (o_mem_req),
        .o_mem_addr           (o_mem_addr),
        .o_fetch_pc1          (fetch_pc1),
        .o_ack_valid          (ack_valid)
    );

    rv_fetch_buf rv_fetch_buf_i (
        .i_clk                (i_clk),
        .i_reset_n            (i_reset_n),
        .i_pc_select          (i_pc_select),
        .i_ack                (ack_valid),
        .i_decode_ready       (i_decode_ready),
        .i_data               (i_mem_data),
        .i_fetch_pc1          (fetch_pc1),
        .i_fetch_pc_next      (i_redirect_pc),
        .o_free_dword_or_more (free_dword_or_more),
        .o_pc_incr            (pc_incr),
        .o_buf_out            (buf_out)
    );

    rv_rvc_expand rv_rvc_expand_i (
        .i_buf   (buf_out),
        .o_instr (exp_instr),
        .o_op    (exp_op)
    );

    rv_predecode rv_predecode_i (
        .i_buf    (buf_out),
        .o_predec (predec)
    );

    rv_fetch_pkt rv_fetch_pkt_i (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_pc_select (i_pc_select),
        .i_buf       (buf_out),
        .i_instr     (exp_instr),
        .i_op        (exp_op),
        .i_predec    (predec),
        .o_pkt       (o_pkt)
    );

endmodule

/* verif/tb_rv_fetch_unit.sv */
`timescale 1ns/1ps

module tb_rv_fetch_unit
    import rv_pkg::*;
();

    localparam int MEM_WORDS    = 256;
    localparam int NUM_PKTS     = 3000;
    localparam int PKT_TIMEOUT  = 300;

    logic        i_clk;
    logic        i_reset_n;
    logic        o_mem_req;
    logic [31:0] o_mem_addr;
    logic        i_mem_ack;
    logic [31:0] i_mem_data;
    logic        i_pc_select;
    logic [31:0] i_redirect_pc;
    logic        i_decode_ready;
    fetch_pkt_t  o_pkt;

    integer      seed = 32'hd049d7f8;
    logic [31:0] mem [0:MEM_WORDS-1];

    // Reference model state
    logic [31:0] exp_pc;
    int          pkt_count;
    int          redirect_count;

    // Memory model state
    logic        mem_busy;
    logic        ack_pending;
    int          ack_wait;
    logic [31:0] ack_word;
    logic [31:0] fetch_addr;
    logic        req_stale;

    rv_fetch_unit rv_fetch_unit_i (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .o_mem_req      (o_mem_req),
        .o_mem_addr     (o_mem_addr),
        .i_mem_ack      (i_mem_ack),
        .i_mem_data     (i_mem_data),
        .i_pc_select    (i_pc_select),
        .i_redirect_pc  (i_redirect_pc),
        .i_decode_ready (i_decode_ready),
        .o_pkt          (o_pkt)
    );

    always #4 i_clk = ~i_clk;

    task automatic stop_on_failure();
        $display("Something failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual)
        else
        begin
            $display("ERR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic put_hword(input int idx, input logic [15:0] h);
        int w;
        w = (idx & 511) >> 1;
        if (idx[0])
            mem[w][31:16] = h;
        else
            mem[w][15:0] = h;
    endtask

    // Program mix leans on the supported RVC forms, ADDI, JAL and BEQ
    task automatic generate_program();
        int          idx;
        int          sel;
        logic [31:0] r;
        logic [31:0] w;
        idx = 0;
        while (idx < 2 * MEM_WORDS)
        begin
            r   = $random(seed);
            sel = {$random(seed)} % 11;
            w   = 32'h0;
            case (sel)
                0: w = {16'h0, 3'b000, r[12:2], 2'b01};
                1: w = {16'h0, 3'b010, r[12:2], 2'b01};
                2: w = {16'h0, 3'b100, r[12:2], 2'b10};
                3: w = {16'h0, 3'b101, r[12:2], 2'b01};
                4: w = {16'h0, 2'b11, r[13], r[12:2], 2'b01};
                5: w = {r[31:7], 7'b0010011};
                6: w = {r[31:7], 7'b1101111};
                7: w = {r[31:15], 2'b00, r[12], r[11:7], 7'b1100011};
                8: w = {16'h0, r[15:2], 1'b0, r[0]};
                9: w = {r[31:15], 3'b000, r[11:7], 7'b1100111};
                default: w = {r[31:2], 2'b11};
            endcase
            put_hword(idx, w[15:0]);
            if (w[1:0] == 2'b11)
            begin
                put_hword(idx + 1, w[31:16]);
                idx = idx + 2;
            end
            else
                idx = idx + 1;
        end
    endtask

    function automatic logic [15:0] read_hword(input logic [31:0] a);
        logic [31:0] w;
        w = mem[a[9:2]];
        return a[1] ? w[31:16] : w[15:0];
    endfunction

    // Jump offset of C.J and C.JAL
    function automatic logic [31:0] cj_offset(input logic [15:0] c);
        logic [11:0] o;
        o[11]  = c[12];
        o[10]  = c[8];
        o[9:8] = c[10:9];
        o[7]   = c[6];
        o[6]   = c[7];
        o[5]   = c[2];
        o[4]   = c[11];
        o[3:1] = c[5:3];
        o[0]   = 1'b0;
        return {{20{o[11]}}, o};
    endfunction

    // Branch offset of C.BEQZ and C.BNEZ
    function automatic logic [31:0] cb_offset(input logic [15:0] c);
        logic [8:0] o;
        o[8]   = c[12];
        o[7:6] = c[6:5];
        o[5]   = c[2];
        o[4:3] = c[11:10];
        o[2:1] = c[4:3];
        o[0]   = 1'b0;
        return {{23{o[8]}}, o};
    endfunction

    // Branch offset of the B-type format
    function automatic logic [31:0] b_offset(input logic [31:0] w);
        logic [12:0] o;
        o[12]   = w[31];
        o[11]   = w[7];
        o[10:5] = w[30:25];
        o[4:1]  = w[11:8];
        o[0]    = 1'b0;
        return {{19{o[12]}}, o};
    endfunction

    // Jump offset of the J-type format
    function automatic logic [31:0] j_offset(input logic [31:0] w);
        logic [20:0] o;
        o[20]    = w[31];
        o[19:12] = w[19:12];
        o[11]    = w[20];
        o[10:1]  = w[30:21];
        o[0]     = 1'b0;
        return {{11{o[20]}}, o};
    endfunction

    function automatic fetch_pkt_t model_packet(input logic [31:0] pc);
        fetch_pkt_t  p;
        logic [15:0] c;
        logic [31:0] w;
        logic [31:0] off;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        c         = read_hword(pc);
        w         = {read_hword(pc + 32'd2), c};
        rd        = c[11:7];
        rs2       = c[6:2];
        p.valid   = 1'b1;
        p.pc      = pc;
        p.is_comp = (c[1:0] != 2'b11);
        p.next_pc = pc + (p.is_comp ? 32'd2 : 32'd4);
        p.target  = p.next_pc;
        p.cls     = CLS_OTHER;
        p.instr   = w;
        if (!p.is_comp)
        begin
            case (w[6:0])
                7'b1100011:
                begin
                    p.cls    = CLS_BRANCH;
                    off      = b_offset(w);
                    p.target = pc + off;
                end
                7'b1101111:
                begin
                    p.cls    = CLS_JAL;
                    off      = j_offset(w);
                    p.target = pc + off;
                end
                7'b1100111: p.cls = CLS_JALR;
                default:    p.cls = CLS_OTHER;
            endcase
        end
        else
        begin
            p.cls   = CLS_ILLEGAL;
            p.instr = 32'h0;
            case ({c[15:13], c[1:0]})
                5'b000_01:
                begin
                    p.cls   = CLS_OTHER;
                    p.instr = {{7{c[12]}}, c[6:2], rd, 3'b000, rd, 7'b0010011};
                end
                5'b010_01:
                begin
                    p.cls   = CLS_OTHER;
                    p.instr = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, rd, 7'b0010011};
                end
                5'b100_10:
                begin
                    if ((rd != 5'd0) && (rs2 != 5'd0))
                    begin
                        p.cls   = CLS_OTHER;
                        p.instr = {7'd0, rs2, (c[12] ? rd : 5'd0), 3'b000, rd, 7'b0110011};
                    end
                end
                5'b101_01:
                begin
                    off      = cj_offset(c);
                    p.cls    = CLS_JAL;
                    p.instr  = {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
                    p.target = pc + off;
                end
                5'b110_01, 5'b111_01:
                begin
                    off      = cb_offset(c);
                    p.cls    = CLS_BRANCH;
                    p.instr  = {off[12], off[10:5], 5'd0, 2'b01, c[9:7], 2'b00, c[13],
                                off[4:1], off[11], 7'b1100011};
                    p.target = pc + off;
                end
                // C.JAL is outside the subset but still has a static target
                5'b001_01: p.target = pc + cj_offset(c);
                default: p.cls = CLS_ILLEGAL;
            endcase
        end
        return p;
    endfunction

    task automatic check_packet();
        fetch_pkt_t e;
        e = model_packet(exp_pc);
        check_value("pkt_pc", e.pc, o_pkt.pc);
        check_value("pkt_is_comp", 32'(e.is_comp), 32'(o_pkt.is_comp));
        check_value("pkt_instr", e.instr, o_pkt.instr);
        check_value("pkt_cls", 32'(e.cls), 32'(o_pkt.cls));
        check_value("pkt_next_pc", e.next_pc, o_pkt.next_pc);
        check_value("pkt_target", e.target, o_pkt.target);
        exp_pc    = e.next_pc;
        pkt_count = pkt_count + 1;
    endtask

    always @(posedge i_clk)
    begin
        if (i_reset_n)
        begin
            // Packet shown in a redirect cycle still belongs to the old stream
            if (o_pkt.valid)
                check_packet();
            if (i_pc_select)
            begin
                exp_pc         = i_redirect_pc;
                redirect_count = redirect_count + 1;
            end

            if (o_mem_req)
            begin
                assert (!mem_busy)
                else
                begin
                    $display("Memory request issued while another one was outstanding");
                    stop_on_failure();
                end
                check_value("mem_addr", fetch_addr, o_mem_addr);
            end
            // Each ack that is kept moves fetching on to the next word
            if (i_mem_ack)
            begin
                if (!req_stale)
                    fetch_addr = fetch_addr + 32'd4;
                req_stale = 1'b0;
            end
            if (i_pc_select)
            begin
                fetch_addr = {i_redirect_pc[31:2], 2'b00};
                req_stale  = mem_busy & !i_mem_ack;
            end
            if (i_mem_ack)
                mem_busy = 1'b0;
            i_mem_ack <= 1'b0;
            if (o_mem_req)
            begin
                mem_busy    = 1'b1;
                ack_pending = 1'b1;
                ack_wait    = {$random(seed)} % 4;
                ack_word    = mem[o_mem_addr[9:2]];
            end
            if (ack_pending)
            begin
                if (ack_wait == 0)
                begin
                    i_mem_ack   <= 1'b1;
                    i_mem_data  <= ack_word;
                    ack_pending = 1'b0;
                end
                else
                    ack_wait = ack_wait - 1;
            end

            i_decode_ready <= ({$random(seed)} % 4) != 0;
            if (!i_pc_select && (({$random(seed)} % 32) == 0))
            begin
                i_pc_select   <= 1'b1;
                i_redirect_pc <= $random(seed) & 32'h0000_03fe;
            end
            else
                i_pc_select <= 1'b0;
        end
    end

    initial
    begin
        int idle;
        int last_count;
        i_clk          = 1'b0;
        i_reset_n      <= 1'b0;
        i_mem_ack      <= 1'b0;
        i_mem_data     <= 32'h0;
        i_pc_select    <= 1'b0;
        i_redirect_pc  <= 32'h0;
        i_decode_ready <= 1'b0;
        exp_pc         = 32'h0;
        pkt_count      = 0;
        redirect_count = 0;
        mem_busy       = 1'b0;
        ack_pending    = 1'b0;
        ack_wait       = 0;
        ack_word       = 32'h0;
        fetch_addr     = 32'h0;
        req_stale      = 1'b0;
        generate_program();

        repeat (3) @(posedge i_clk);
        i_reset_n <= 1'b1;

        idle       = 0;
        last_count = 0;
        while (pkt_count < NUM_PKTS)
        begin
            @(negedge i_clk);
            if (pkt_count != last_count)
            begin
                idle       = 0;
                last_count = pkt_count;
            end
            else
                idle = idle + 1;
            if (idle > PKT_TIMEOUT)
            begin
                $display("Timeout, no packet arrived for %0d cycles", PKT_TIMEOUT);
                stop_on_failure();
            end
        end

        $display("Checked %0d packets across %0d redirects", pkt_count, redirect_count);
        $display("Everything OK");
        $finish;
    end

endmodule

/* sim.f */
hdl/rv_pkg.sv
hdl/rv_fetch_ctrl.sv
hdl/rv_fetch_buf.sv
hdl/rv_rvc_expand.sv
hdl/rv_predecode.sv
hdl/rv_fetch_pkt.sv
hdl/rv_fetch_unit.sv
verif/tb_rv_fetch_unit.sv

/* run.sh */
#!/bin/sh
# Build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_rv_fetch_unit -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "^Everything OK$" sim.log; then
    exit 0
fi
exit 1
